// File: project.f
verilog/trace_cfg_pkg.sv
verilog/rv_isa_pkg.sv
verilog/commit_if.sv
verilog/trace_if.sv
verilog/commit_capture.sv
verilog/commit_queue.sv
verilog/writeback_merge.sv
verilog/trace_emitter.sv
verilog/commit_trace_top.sv
testbench/commit_trace_tb.sv

// File: testbench/commit_trace_tb.sv
module commit_trace_tb;

  logic                                     clk_i;
  logic                                     rst_n_i;
  logic [trace_cfg_pkg::hart_id_width-1:0]  hart_id_i;
  logic                                     commit_v_i;
  logic [trace_cfg_pkg::vaddr_width-1:0]    commit_pc_i;
  logic [trace_cfg_pkg::instr_width-1:0]    commit_instr_i;
  logic                                     ird_w_v_i;
  logic [trace_cfg_pkg::reg_addr_width-1:0] ird_addr_i;
  logic [trace_cfg_pkg::data_width-1:0]     ird_data_i;
  logic                                     frd_w_v_i;
  logic [trace_cfg_pkg::reg_addr_width-1:0] frd_addr_i;
  logic [trace_cfg_pkg::data_width-1:0]     frd_data_i;
  logic                                     trace_ack_i;
  logic                                     trace_req_o;
  logic [trace_cfg_pkg::hart_id_width-1:0]  trace_hart_o;
  logic [trace_cfg_pkg::vaddr_width-1:0]    trace_pc_o;
  logic [trace_cfg_pkg::instr_width-1:0]    trace_instr_o;
  logic [trace_cfg_pkg::itag_width-1:0]     trace_itag_o;
  logic                                     trace_rd_v_o;
  logic                                     trace_rd_fp_o;
  logic [trace_cfg_pkg::reg_addr_width-1:0] trace_rd_addr_o;
  logic [trace_cfg_pkg::data_width-1:0]     trace_rd_data_o;
  logic                                     overflow_o;

  // every driven commit and writeback in order
  logic [trace_cfg_pkg::vaddr_width-1:0]    pc_log[$];
  logic [trace_cfg_pkg::instr_width-1:0]    instr_log[$];
  logic [trace_cfg_pkg::reg_addr_width-1:0] wb_addr_log[$];
  logic [trace_cfg_pkg::data_width-1:0]     wb_data_log[$];
  logic                                     wb_fp_log[$];

  integer                               seed;
  string                                test_name;
  int                                   received;
  int                                   wb_received;
  int                                   ack_delay_max;
  int                                   delay;
  int                                   cycles;
  int                                   i;
  int                                   w;
  logic                                 ack_hold;
  logic [31:0]                          r;
  logic [trace_cfg_pkg::itag_width-1:0] exp_itag;

  commit_trace_top u_commit_trace_top (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic logic writes_reg(input logic [trace_cfg_pkg::instr_width-1:0] instr);
    logic hit;
    case (instr[rv_isa_pkg::opcode_hi:rv_isa_pkg::opcode_lo])
      rv_isa_pkg::opcode_op, rv_isa_pkg::opcode_op_imm, rv_isa_pkg::opcode_op_32,
      rv_isa_pkg::opcode_op_imm_32, rv_isa_pkg::opcode_load, rv_isa_pkg::opcode_lui,
      rv_isa_pkg::opcode_auipc, rv_isa_pkg::opcode_jal, rv_isa_pkg::opcode_jalr,
      rv_isa_pkg::opcode_load_fp, rv_isa_pkg::opcode_op_fp:
        hit = 1'b1;
      default:
        hit = 1'b0;
    endcase
    // x0 as destination writes nothing
    return hit & (|instr[rv_isa_pkg::rd_hi:rv_isa_pkg::rd_lo]);
  endfunction

  // index of the writeback paired with commit idx or -1 without a write
  function automatic int paired_wb(input int idx);
    int n;
    n = 0;
    for (int k = 0; k < idx; k++)
      n += int'(writes_reg(instr_log[k]));
    return writes_reg(instr_log[idx]) ? n : -1;
  endfunction

  task automatic check_field(input string name,
                             input logic [trace_cfg_pkg::vaddr_width-1:0] exp,
                             input logic [trace_cfg_pkg::vaddr_width-1:0] act);
    if (exp !== act)
    begin
      $display("Fail %s %s: expected %0h, actual %0h", test_name, name, exp, act);
      $display("Test failures found");
      $fatal(1, "field mismatch");
    end
  endtask

  task automatic check_data(input string name,
                            input logic [trace_cfg_pkg::data_width-1:0] exp,
                            input logic [trace_cfg_pkg::data_width-1:0] act);
    if (exp !== act)
    begin
      $display("Fail %s %s: expected %0h, actual %0h", test_name, name, exp, act);
      $display("Test failures found");
      $fatal(1, "data mismatch");
    end
  endtask

  task automatic send_commit(input logic [rv_isa_pkg::opcode_width-1:0] op,
                             input logic [trace_cfg_pkg::reg_addr_width-1:0] rd);
    logic [31:0] bits;
    bits = $random(seed);
    @(posedge clk_i);
    #5;
    commit_v_i     = 1'b1;
    commit_instr_i = {bits[31:12], rd, op};
    pc_log.push_back(commit_pc_i);
    instr_log.push_back(commit_instr_i);
    @(posedge clk_i);
    #5;
    commit_v_i  = 1'b0;
    commit_pc_i = commit_pc_i + 4;
  endtask

  // the idle port carries inverted values so a wrong port pick shows up
  task automatic send_wb(input logic fp, input logic [trace_cfg_pkg::reg_addr_width-1:0] rd);
    logic [trace_cfg_pkg::data_width-1:0] d;
    d = {$random(seed), $random(seed)};
    @(posedge clk_i);
    #5;
    ird_w_v_i  = ~fp;
    frd_w_v_i  = fp;
    ird_addr_i = fp ? ~rd : rd;
    ird_data_i = fp ? ~d : d;
    frd_addr_i = fp ? rd : ~rd;
    frd_data_i = fp ? d : ~d;
    wb_addr_log.push_back(rd);
    wb_data_log.push_back(d);
    wb_fp_log.push_back(fp);
    @(posedge clk_i);
    #5;
    ird_w_v_i = 1'b0;
    frd_w_v_i = 1'b0;
  endtask

  task automatic wait_drained();
    while (received < pc_log.size())
      @(posedge clk_i);
  endtask

  // ack side of the trace port
  initial
  begin
    forever
    begin
      @(negedge clk_i);
      if (trace_req_o)
      begin
        if (received >= pc_log.size())
        begin
          $display("Error: trace record raised with no commit left to match it");
          $display("Test failures found");
          $fatal(1, "unexpected record");
        end
        w        = paired_wb(received);
        exp_itag = received;
        check_field("pc", pc_log[received], trace_pc_o);
        check_field("instr", instr_log[received], trace_instr_o);
        check_field("itag", exp_itag, trace_itag_o);
        check_field("hart", hart_id_i, trace_hart_o);
        check_field("rd_v", w >= 0, trace_rd_v_o);
        check_field("rd_fp", (w >= 0) ? wb_fp_log[w] : 1'b0, trace_rd_fp_o);
        check_field("rd_addr", (w >= 0) ? wb_addr_log[w] : 5'd0, trace_rd_addr_o);
        check_data("rd_data", (w >= 0) ? wb_data_log[w] : 64'd0, trace_rd_data_o);
        wb_received = wb_received + int'(w >= 0);
        received    = received + 1;
        delay       = $unsigned($random(seed)) % (ack_delay_max + 1);
        repeat (delay) @(posedge clk_i);
        while (ack_hold)
          @(posedge clk_i);
        @(posedge clk_i);
        #5 trace_ack_i = 1'b1;
        while (trace_req_o)
          @(negedge clk_i);
        @(posedge clk_i);
        #5 trace_ack_i = 1'b0;
      end
    end
  end

  initial
  begin
    cycles = 0;
    while (cycles < 40 * pc_log.size() + 200)
    begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout: trace records stopped arriving before the tests finished");
    $display("Test failures found");
    $fatal(1, "timeout");
  end

  initial
  begin
    seed           = 32'h4cbb95a0;
    rst_n_i        = 1'b0;
    hart_id_i      = 4'h9;
    commit_v_i     = 1'b0;
    commit_pc_i    = 39'h00_8000_0000;
    commit_instr_i = '0;
    ird_w_v_i      = 1'b0;
    ird_addr_i     = '0;
    ird_data_i     = '0;
    frd_w_v_i      = 1'b0;
    frd_addr_i     = '0;
    frd_data_i     = '0;
    trace_ack_i    = 1'b0;
    ack_hold       = 1'b0;
    ack_delay_max  = 0;
    received       = 0;
    wb_received    = 0;
    repeat (3) @(posedge clk_i);
    #5 rst_n_i = 1'b1;

    test_name = "int_alu_stream";
    for (i = 1; i < 7; i++)
    begin
      send_commit(i[0] ? rv_isa_pkg::opcode_op : rv_isa_pkg::opcode_op_imm, i);
      send_wb(1'b0, i);
    end
    wait_drained();

    test_name = "no_write_mix";
    // store with an immediate in the rd bits
    send_commit(7'b0100011, 5'd3);
    send_commit(rv_isa_pkg::opcode_lui, 5'd7);
    send_wb(1'b0, 5'd7);
    send_commit(7'b1100011, 5'd9);
    send_commit(rv_isa_pkg::opcode_op, 5'd0);
    send_commit(rv_isa_pkg::opcode_jal, 5'd1);
    send_wb(1'b0, 5'd1);
    send_commit(rv_isa_pkg::opcode_load, 5'd0);
    wait_drained();

    test_name = "fp_late_writeback";
    send_commit(rv_isa_pkg::opcode_load_fp, 5'd2);
    send_commit(rv_isa_pkg::opcode_op_fp, 5'd4);
    send_commit(rv_isa_pkg::opcode_op_fp, 5'd6);
    send_commit(rv_isa_pkg::opcode_op_imm_32, 5'd8);
    // writebacks trail their commits by several slots
    send_wb(1'b1, 5'd2);
    send_wb(1'b1, 5'd4);
    send_wb(1'b1, 5'd6);
    send_wb(1'b0, 5'd8);
    wait_drained();

    test_name     = "random_ack_delay";
    ack_delay_max = 6;
    for (i = 0; i < 30; i++)
    begin
      while (pc_log.size() - received >= 6)
        @(posedge clk_i);
      r = $random(seed);
      // keep pending writebacks within the merge buffer
      if (r[0] && (wb_addr_log.size() - wb_received < 4))
      begin
        send_commit(r[1] ? rv_isa_pkg::opcode_op_fp : rv_isa_pkg::opcode_auipc, r[6:2] | 5'd1);
        send_wb(r[1], r[6:2] | 5'd1);
      end
      else
      begin
        send_commit(r[1] ? 7'b1100011 : rv_isa_pkg::opcode_jalr, 5'd0);
      end
    end
    wait_drained();
    @(negedge clk_i);
    check_field("overflow", 1'b0, overflow_o);

    test_name = "overflow_sticky";
    repeat (12) @(posedge clk_i);
    ack_hold = 1'b1;
    for (i = 0; i < 14; i++)
      send_commit(7'b1100011, 5'd0);
    repeat (4) @(negedge clk_i);
    check_field("overflow", 1'b1, overflow_o);
    repeat (20) @(negedge clk_i);
    check_field("overflow_held", 1'b1, overflow_o);

    $display("All tests passed!");
    $finish;
  end

endmodule

// File: verilog/commit_capture.sv
module commit_capture (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  logic                                   commit_v_i,
  input  logic [trace_cfg_pkg::vaddr_width-1:0]  commit_pc_i,
  input  logic [trace_cfg_pkg::instr_width-1:0]  commit_instr_i,
  commit_if.producer                             out_if
);

  logic [trace_cfg_pkg::itag_width-1:0]     itag_cnt;
  logic [rv_isa_pkg::opcode_width-1:0]      opcode;
  logic [trace_cfg_pkg::reg_addr_width-1:0] rd;
  logic                                     is_int_op;
  logic                                     is_fp_op;

  assign opcode = commit_instr_i[rv_isa_pkg::opcode_hi:rv_isa_pkg::opcode_lo];
  assign rd     = commit_instr_i[rv_isa_pkg::rd_hi:rv_isa_pkg::rd_lo];

  always_comb
  begin
    is_int_op = 1'b0;
    is_fp_op  = 1'b0;
    case (opcode)
      rv_isa_pkg::opcode_op,
      rv_isa_pkg::opcode_op_imm,
      rv_isa_pkg::opcode_op_32,
      rv_isa_pkg::opcode_op_imm_32,
      rv_isa_pkg::opcode_load,
      rv_isa_pkg::opcode_lui,
      rv_isa_pkg::opcode_auipc,
      rv_isa_pkg::opcode_jal,
      rv_isa_pkg::opcode_jalr:
        is_int_op = 1'b1;
      rv_isa_pkg::opcode_load_fp,
      rv_isa_pkg::opcode_op_fp:
        is_fp_op = 1'b1;
      default:
        is_int_op = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      out_if.v <= 1'b0;
      itag_cnt <= '0;
    end
    else
    begin
      out_if.v <= commit_v_i | (out_if.v & ~out_if.yumi);
      if (commit_v_i)
      begin
        itag_cnt <= itag_cnt + 1'b1;
      end
    end
  end

  // rd of zero means no register is written
  always_ff @(posedge clk_i)
  begin
    if (commit_v_i)
    begin
      out_if.pc     <= commit_pc_i;
      out_if.instr  <= commit_instr_i;
      out_if.itag   <= itag_cnt;
      out_if.wb_int <= is_int_op & (|rd);
      out_if.wb_fp  <= is_fp_op & (|rd);
    end
  end

endmodule

// File: verilog/commit_if.sv
interface commit_if;

  logic                                   v;
  logic                                   yumi;
  logic [trace_cfg_pkg::vaddr_width-1:0]  pc;
  logic [trace_cfg_pkg::instr_width-1:0]  instr;
  logic [trace_cfg_pkg::itag_width-1:0]   itag;
  // expected destination file
  logic                                   wb_int;
  logic                                   wb_fp;

  modport producer (
    output v, pc, instr, itag, wb_int, wb_fp,
    input  yumi
  );

  modport consumer (
    input  v, pc, instr, itag, wb_int, wb_fp,
    output yumi
  );

endinterface

// File: verilog/commit_queue.sv
module commit_queue (
  input  logic       clk_i,
  input  logic       rst_n_i,
  commit_if.consumer in_if,
  commit_if.producer out_if,
  output logic       overflow_o
);

  logic [trace_cfg_pkg::vaddr_width-1:0] pc_mem    [trace_cfg_pkg::commit_queue_depth];
  logic [trace_cfg_pkg::instr_width-1:0] instr_mem [trace_cfg_pkg::commit_queue_depth];
  logic [trace_cfg_pkg::itag_width-1:0]  itag_mem  [trace_cfg_pkg::commit_queue_depth];
  logic                                  int_mem   [trace_cfg_pkg::commit_queue_depth];
  logic                                  fp_mem    [trace_cfg_pkg::commit_queue_depth];

  logic [trace_cfg_pkg::commit_queue_ptr_width-1:0] wr_ptr;
  logic [trace_cfg_pkg::commit_queue_ptr_width-1:0] rd_ptr;
  logic [trace_cfg_pkg::commit_queue_ptr_width:0]   count;
  logic                                             full;
  logic                                             push;
  logic                                             pop;

  // count msb set means all entries used
  assign full = count[trace_cfg_pkg::commit_queue_ptr_width];
  assign push = in_if.v & ~full;
  assign pop  = out_if.v & out_if.yumi;

  // every item is taken at once and either stored or dropped
  assign in_if.yumi = in_if.v;

  assign out_if.v      = |count;
  assign out_if.pc     = pc_mem[rd_ptr];
  assign out_if.instr  = instr_mem[rd_ptr];
  assign out_if.itag   = itag_mem[rd_ptr];
  assign out_if.wb_int = int_mem[rd_ptr];
  assign out_if.wb_fp  = fp_mem[rd_ptr];

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      overflow_o <= 1'b0;
    end
    else
    begin
      if (push)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      if (in_if.v & full)
      begin
        overflow_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push)
    begin
      pc_mem[wr_ptr]    <= in_if.pc;
      instr_mem[wr_ptr] <= in_if.instr;
      itag_mem[wr_ptr]  <= in_if.itag;
      int_mem[wr_ptr]   <= in_if.wb_int;
      fp_mem[wr_ptr]    <= in_if.wb_fp;
    end
  end

endmodule

// File: verilog/commit_trace_top.sv
module commit_trace_top (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,
  input  logic [trace_cfg_pkg::hart_id_width-1:0]  hart_id_i,
  input  logic                                     commit_v_i,
  input  logic [trace_cfg_pkg::vaddr_width-1:0]    commit_pc_i,
  input  logic [trace_cfg_pkg::instr_width-1:0]    commit_instr_i,
  input  logic                                     ird_w_v_i,
  input  logic [trace_cfg_pkg::reg_addr_width-1:0] ird_addr_i,
  input  logic [trace_cfg_pkg::data_width-1:0]     ird_data_i,
  input  logic                                     frd_w_v_i,
  input  logic [trace_cfg_pkg::reg_addr_width-1:0] frd_addr_i,
  input  logic [trace_cfg_pkg::data_width-1:0]     frd_data_i,
  input  logic                                     trace_ack_i,
  output logic                                     trace_req_o,
  output logic [trace_cfg_pkg::hart_id_width-1:0]  trace_hart_o,
  output logic [trace_cfg_pkg::vaddr_width-1:0]    trace_pc_o,
  output logic [trace_cfg_pkg::instr_width-1:0]    trace_instr_o,
  output logic [trace_cfg_pkg::itag_width-1:0]     trace_itag_o,
  output logic                                     trace_rd_v_o,
  output logic                                     trace_rd_fp_o,
  output logic [trace_cfg_pkg::reg_addr_width-1:0] trace_rd_addr_o,
  output logic [trace_cfg_pkg::data_width-1:0]     trace_rd_data_o,
  output logic                                     overflow_o
);

  commit_if cap_if ();
  commit_if head_if ();
  trace_if  rec_if ();

  logic queue_overflow;
  logic wb_overflow;

  // hart id is a static strap
  assign trace_hart_o = hart_id_i;
  assign overflow_o   = queue_overflow | wb_overflow;

  commit_capture u_commit_capture (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .commit_v_i     (commit_v_i),
    .commit_pc_i    (commit_pc_i),
    .commit_instr_i (commit_instr_i),
    .out_if         (cap_if.producer)
  );

  commit_queue u_commit_queue (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .in_if      (cap_if.consumer),
    .out_if     (head_if.producer),
    .overflow_o (queue_overflow)
  );

  writeback_merge u_writeback_merge (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .ird_w_v_i     (ird_w_v_i),
    .ird_addr_i    (ird_addr_i),
    .ird_data_i    (ird_data_i),
    .frd_w_v_i     (frd_w_v_i),
    .frd_addr_i    (frd_addr_i),
    .frd_data_i    (frd_data_i),
    .in_if         (head_if.consumer),
    .out_if        (rec_if.producer),
    .wb_overflow_o (wb_overflow)
  );

  trace_emitter u_trace_emitter (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .trace_ack_i     (trace_ack_i),
    .in_if           (rec_if.consumer),
    .trace_req_o     (trace_req_o),
    .trace_pc_o      (trace_pc_o),
    .trace_instr_o   (trace_instr_o),
    .trace_itag_o    (trace_itag_o),
    .trace_rd_v_o    (trace_rd_v_o),
    .trace_rd_fp_o   (trace_rd_fp_o),
    .trace_rd_addr_o (trace_rd_addr_o),
    .trace_rd_data_o (trace_rd_data_o)
  );

endmodule

// File: verilog/rv_isa_pkg.sv
package rv_isa_pkg;

  // field positions inside the instruction word
  localparam int opcode_lo    = 0;
  localparam int opcode_hi    = 6;
  localparam int opcode_width = opcode_hi - opcode_lo + 1;
  localparam int rd_lo        = 7;
  localparam int rd_hi        = 11;

  // opcodes that write the integer file
  localparam logic [opcode_width-1:0] opcode_load      = 7'b0000011;
  localparam logic [opcode_width-1:0] opcode_op_imm    = 7'b0010011;
  localparam logic [opcode_width-1:0] opcode_auipc     = 7'b0010111;
  localparam logic [opcode_width-1:0] opcode_op_imm_32 = 7'b0011011;
  localparam logic [opcode_width-1:0] opcode_op        = 7'b0110011;
  localparam logic [opcode_width-1:0] opcode_lui       = 7'b0110111;
  localparam logic [opcode_width-1:0] opcode_op_32     = 7'b0111011;
  localparam logic [opcode_width-1:0] opcode_jalr      = 7'b1100111;
  localparam logic [opcode_width-1:0] opcode_jal       = 7'b1101111;

  // opcodes that write the fp file
  localparam logic [opcode_width-1:0] opcode_load_fp = 7'b0000111;
  localparam logic [opcode_width-1:0] opcode_op_fp   = 7'b1010011;

endpackage

// File: verilog/trace_cfg_pkg.sv
package trace_cfg_pkg;

  // datapath widths
  localparam int vaddr_width    = 39;
  localparam int instr_width    = 32;
  localparam int reg_addr_width = 5;
  localparam int data_width     = 64;
  localparam int hart_id_width  = 4;

  // tag counter wraps at this width
  localparam int itag_width = 30;

  // buffer depths are powers of two
  localparam int commit_queue_depth     = 8;
  localparam int commit_queue_ptr_width = $clog2(commit_queue_depth);
  localparam int wb_buffer_depth        = 4;
  localparam int wb_buffer_ptr_width    = $clog2(wb_buffer_depth);

  // trace port FSM encoding
  localparam int emit_state_width = 2;
  localparam logic [emit_state_width-1:0] emit_idle  = 2'd0;
  localparam logic [emit_state_width-1:0] emit_req   = 2'd1;
  localparam logic [emit_state_width-1:0] emit_drain = 2'd2;

endpackage

// File: verilog/trace_emitter.sv
module trace_emitter (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,
  input  logic                                     trace_ack_i,
  trace_if.consumer                                in_if,
  output logic                                     trace_req_o,
  output logic [trace_cfg_pkg::vaddr_width-1:0]    trace_pc_o,
  output logic [trace_cfg_pkg::instr_width-1:0]    trace_instr_o,
  output logic [trace_cfg_pkg::itag_width-1:0]     trace_itag_o,
  output logic                                     trace_rd_v_o,
  output logic                                     trace_rd_fp_o,
  output logic [trace_cfg_pkg::reg_addr_width-1:0] trace_rd_addr_o,
  output logic [trace_cfg_pkg::data_width-1:0]     trace_rd_data_o
);

  logic [trace_cfg_pkg::emit_state_width-1:0] state;
  logic                                       load;

  assign load        = (state == trace_cfg_pkg::emit_idle) & in_if.v;
  assign trace_req_o = (state == trace_cfg_pkg::emit_req);

  // release the record only after ack has dropped
  assign in_if.yumi = (state == trace_cfg_pkg::emit_drain) & ~trace_ack_i;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state <= trace_cfg_pkg::emit_idle;
    end
    else
    begin
      case (state)
        trace_cfg_pkg::emit_idle:
          if (in_if.v)
          begin
            state <= trace_cfg_pkg::emit_req;
          end
        trace_cfg_pkg::emit_req:
          if (trace_ack_i)
          begin
            state <= trace_cfg_pkg::emit_drain;
          end
        trace_cfg_pkg::emit_drain:
          if (!trace_ack_i)
          begin
            state <= trace_cfg_pkg::emit_idle;
          end
        default:
          state <= trace_cfg_pkg::emit_idle;
      endcase
    end
  end

  // record held stable for the whole exchange
  always_ff @(posedge clk_i)
  begin
    if (load)
    begin
      trace_pc_o      <= in_if.pc;
      trace_instr_o   <= in_if.instr;
      trace_itag_o    <= in_if.itag;
      trace_rd_v_o    <= in_if.rd_v;
      trace_rd_fp_o   <= in_if.rd_fp;
      trace_rd_addr_o <= in_if.rd_addr;
      trace_rd_data_o <= in_if.rd_data;
    end
  end

endmodule

// File: verilog/trace_if.sv
interface trace_if;

  logic                                     v;
  logic                                     yumi;
  logic [trace_cfg_pkg::vaddr_width-1:0]    pc;
  logic [trace_cfg_pkg::instr_width-1:0]    instr;
  logic [trace_cfg_pkg::itag_width-1:0]     itag;
  logic                                     rd_v;
  logic                                     rd_fp;
  logic [trace_cfg_pkg::reg_addr_width-1:0] rd_addr;
  logic [trace_cfg_pkg::data_width-1:0]     rd_data;

  modport producer (
    output v, pc, instr, itag, rd_v, rd_fp, rd_addr, rd_data,
    input  yumi
  );

  modport consumer (
    input  v, pc, instr, itag, rd_v, rd_fp, rd_addr, rd_data,
    output yumi
  );

endinterface

// File: verilog/writeback_merge.sv
module writeback_merge (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,
  input  logic                                     ird_w_v_i,
  input  logic [trace_cfg_pkg::reg_addr_width-1:0] ird_addr_i,
  input  logic [trace_cfg_pkg::data_width-1:0]     ird_data_i,
  input  logic                                     frd_w_v_i,
  input  logic [trace_cfg_pkg::reg_addr_width-1:0] frd_addr_i,
  input  logic [trace_cfg_pkg::data_width-1:0]     frd_data_i,
  commit_if.consumer                               in_if,
  trace_if.producer                                out_if,
  output logic                                     wb_overflow_o
);

  logic [trace_cfg_pkg::reg_addr_width-1:0] wb_addr_mem [trace_cfg_pkg::wb_buffer_depth];
  logic [trace_cfg_pkg::data_width-1:0]     wb_data_mem [trace_cfg_pkg::wb_buffer_depth];
  logic                                     wb_fp_mem   [trace_cfg_pkg::wb_buffer_depth];

  logic [trace_cfg_pkg::wb_buffer_ptr_width-1:0] wb_wr_ptr;
  logic [trace_cfg_pkg::wb_buffer_ptr_width-1:0] wb_rd_ptr;
  logic [trace_cfg_pkg::wb_buffer_ptr_width:0]   wb_count;

  logic                                     wb_in_v;
  logic                                     wb_in_fp;
  logic [trace_cfg_pkg::reg_addr_width-1:0] wb_in_addr;
  logic [trace_cfg_pkg::data_width-1:0]     wb_in_data;
  logic                                     wb_full;
  logic                                     wb_push;
  logic                                     wb_pop;
  logic                                     needs_wb;
  logic                                     can_load;
  logic                                     take;

  // integer port wins if both fire together
  assign wb_in_v    = ird_w_v_i | frd_w_v_i;
  assign wb_in_fp   = ~ird_w_v_i;
  assign wb_in_addr = ird_w_v_i ? ird_addr_i : frd_addr_i;
  assign wb_in_data = ird_w_v_i ? ird_data_i : frd_data_i;

  assign wb_full = wb_count[trace_cfg_pkg::wb_buffer_ptr_width];
  assign wb_push = wb_in_v & ~wb_full;

  // head waits here until its writeback shows up
  assign needs_wb = in_if.wb_int | in_if.wb_fp;
  assign can_load = ~out_if.v | out_if.yumi;
  assign take     = in_if.v & can_load & (~needs_wb | (|wb_count));
  assign wb_pop   = take & needs_wb;

  assign in_if.yumi = take;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      out_if.v      <= 1'b0;
      wb_wr_ptr     <= '0;
      wb_rd_ptr     <= '0;
      wb_count      <= '0;
      wb_overflow_o <= 1'b0;
    end
    else
    begin
      if (take)
      begin
        out_if.v <= 1'b1;
      end
      else if (out_if.yumi)
      begin
        out_if.v <= 1'b0;
      end
      if (wb_push)
      begin
        wb_wr_ptr <= wb_wr_ptr + 1'b1;
      end
      if (wb_pop)
      begin
        wb_rd_ptr <= wb_rd_ptr + 1'b1;
      end
      case ({wb_push, wb_pop})
        2'b10:   wb_count <= wb_count + 1'b1;
        2'b01:   wb_count <= wb_count - 1'b1;
        default: wb_count <= wb_count;
      endcase
      if (wb_in_v & wb_full)
      begin
        wb_overflow_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (wb_push)
    begin
      wb_addr_mem[wb_wr_ptr] <= wb_in_addr;
      wb_data_mem[wb_wr_ptr] <= wb_in_data;
      wb_fp_mem[wb_wr_ptr]   <= wb_in_fp;
    end
  end

  // rd_fp reports what arrived, not what the opcode promised
  always_ff @(posedge clk_i)
  begin
    if (take)
    begin
      out_if.pc      <= in_if.pc;
      out_if.instr   <= in_if.instr;
      out_if.itag    <= in_if.itag;
      out_if.rd_v    <= needs_wb;
      out_if.rd_fp   <= needs_wb & wb_fp_mem[wb_rd_ptr];
      out_if.rd_addr <= needs_wb ? wb_addr_mem[wb_rd_ptr] : '0;
      out_if.rd_data <= needs_wb ? wb_data_mem[wb_rd_ptr] : '0;
    end
  end

endmodule
